// File: bench/fds_mapper_properties.sv
// fds mapper properties: PRG bank extension and irq state after reset

module fds_mapper_properties (
	input logic                           clk20,
	input logic                           reset,
	input logic [fds_pkg::ext_addr_w-1:0] prg_aout,
	input logic                           irq
);

	int fail_count = 0;  // read by the bench at the end of the run

	// upper address bits are either all clear or all set
	bank_ext_a: assert property (@(posedge clk20) disable iff (reset)
			prg_aout[21:19] == 3'b000 || prg_aout[21:19] == 3'b111)
		else begin
			fail_count++;
			$error("prg_aout bits 21:19 are neither 000 nor 111");
		end

	irq_reset_a: assert property (@(posedge clk20) reset |=> !irq)
		else begin
			fail_count++;
			$error("irq is high in the cycle after reset");
		end

endmodule

// File: include/fds_bench_tasks.svh
// fds bench helpers: cpu bus cycles, expected disk offsets and the directed tests

`ifndef fds_bench_tasks_svh
`define fds_bench_tasks_svh

// four clk20 cycles, cpu_ce high in the last; outputs sampled before the strobe edge
task automatic cpu_cycle(input logic [15:0] addr, input logic [7:0] data, input logic write,
		output logic [7:0] rdata);
	prg_ain   = addr;
	prg_din   = data;
	prg_write = write;
	repeat (3) begin
		@(posedge clk20);
		#1;
	end
	cpu_ce = 1'b1;
	#20;
	rdata      = prg_dout;
	seen_aout  = prg_aout;
	seen_drive = prg_bus_drive;
	@(posedge clk20);
	#1;
	cpu_ce = 1'b0;
endtask

task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
	logic [7:0] unused_rd;
	cpu_cycle(addr, data, 1'b1, unused_rd);
endtask

task automatic bus_read(input logic [15:0] addr, output logic [7:0] rdata);
	cpu_cycle(addr, 8'h00, 1'b0, rdata);
endtask

task automatic idle_strobe();
	logic [7:0] unused_rd;
	cpu_cycle(16'h0000, 8'h00, 1'b0, unused_rd);  // nothing mapped at $0000
endtask

task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
	assert (act === exp) else begin
		$display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
		stop_on_error();
	end
endtask

// bus address and direction held without a strobe
task automatic allow_check(input string name, input logic [15:0] addr, input logic write,
		input logic exp);
	prg_ain   = addr;
	prg_write = write;
	@(posedge clk20);
	#1;
	compare(name, exp, prg_allow);
endtask

// header, then whole sides, then the byte position
function automatic logic [17:0] expected_offset(input logic [1:0] side, input int pos);
	return 18'd16 + 18'd65500 * side + 18'(pos);
endfunction

task automatic reset_defaults();
	logic [7:0] rd;
	compare("reset_defaults irq", 0, irq);
	compare("reset_defaults disk_side_auto", 0, disk_side_auto);
	bus_read(16'h4208, rd);
	compare("reset_defaults saved", 0, rd);
endtask

task automatic timer_one_shot();
	logic [7:0] rd;
	int n;
	int strobes;
	n = 3 + int'($urandom % 6);
	bus_write(16'h4023, 8'h01);
	bus_write(16'h4020, n[7:0]);
	bus_write(16'h4021, 8'h00);
	bus_write(16'h4022, 8'h02);  // start, no repeat
	strobes = 0;
	while (!irq && strobes < n + 10) begin
		idle_strobe();
		strobes++;
	end
	assert (irq) else begin
		$display("timer_one_shot: timed out waiting for irq");
		stop_on_error();
	end
	compare("timer_one_shot strobes", n + 1, strobes);
	bus_read(16'h4030, rd);
	compare("timer_one_shot irq status", 1, rd);
	compare("timer_one_shot irq ack", 0, irq);
	repeat (2 * n) begin
		idle_strobe();
		compare("timer_one_shot stays low", 0, irq);
	end
endtask

task automatic disk_read_sequence();
	logic [7:0] rd;
	logic [17:0] off;
	int pos;
	disk_side = 2'd1;
	for (pos = 0; pos < 2; pos++) begin
		off = expected_offset(2'd1, pos);
		bus_read(16'hF4D0, rd);
		compare("disk_read_sequence lo", off[7:0], rd);
		bus_read(16'hF4D1, rd);
		compare("disk_read_sequence hi", {3'b111, off[12:8]}, rd);
		bus_read(16'hE000, rd);  // transfer cycle
		compare("disk_read_sequence bank", {3'b111, 1'b1, off[17:13], 13'h0000}, seen_aout);
		compare("disk_read_sequence drive", 0, seen_drive);
	end
	bus_read(16'hE000, rd);
	compare("disk_read_sequence bios bank", 0, seen_aout);
endtask

task automatic disk_reset();
	logic [7:0] rd;
	logic [17:0] off;
	int side;
	bus_write(16'h4025, 8'h06);  // reset bit set, read mode
	idle_strobe();
	bus_write(16'h4025, 8'h04);
	for (side = 1; side < 3; side++) begin
		disk_side = side[1:0];
		off = expected_offset(side[1:0], 0);
		bus_read(16'hF4D0, rd);
		compare("disk_reset lo", off[7:0], rd);
		bus_read(16'hF4CE, rd);  // hi byte without starting a transfer
		compare("disk_reset hi", {3'b111, off[12:8]}, rd);
	end
endtask

task automatic disk_write_sequence();
	logic [7:0] rd;
	bus_write(16'h4025, 8'h00);  // write mode
	bus_read(16'hF4CD, rd);
	bus_read(16'hF4CE, rd);
	allow_check("disk_write_sequence allow", 16'hF000, 1'b1, 1'b1);  // bios area writable now
	bus_read(16'h4208, rd);
	compare("disk_write_sequence before", 0, rd);
	bus_read(16'h4208, rd);
	compare("disk_write_sequence saved", 1, rd);
endtask

task automatic mirror_check(input logic [13:0] chr, input logic exp);
	chr_ain = chr;
	@(posedge clk20);
	#1;
	compare("status_and_mirroring vram_a10", exp, vram_a10);
	compare("status_and_mirroring chr_aout", 32'h0010_0000 + chr[12:0], chr_aout);
	compare("status_and_mirroring vram_ce", chr[13], vram_ce);
endtask

task automatic status_and_mirroring();
	logic [7:0] rd;
	logic [7:0] ram_val;
	disk_eject = 1'b1;
	bus_read(16'h4032, rd);
	compare("status_and_mirroring eject", 8'h05, rd);  // disk not at its end
	disk_eject = 1'b0;
	bus_read(16'h4032, rd);
	compare("status_and_mirroring no eject", 8'h00, rd);
	drive_busy = 1'b1;
	bus_read(16'h4029, rd);
	compare("status_and_mirroring busy", 8'h00, rd);
	drive_busy = 1'b0;
	bus_read(16'h4029, rd);
	compare("status_and_mirroring ready", 8'h01, rd);
	bus_read(16'h4033, rd);
	compare("status_and_mirroring power", 8'h80, rd);
	ram_val = 8'($urandom);
	ram_dout = ram_val;
	bus_read(16'h6123, rd);
	compare("status_and_mirroring ram data", ram_val, rd);
	compare("status_and_mirroring ram drive", 0, seen_drive);
	compare("status_and_mirroring ram bank", 22'h00E123, seen_aout);
	allow_check("status_and_mirroring allow wram", 16'h6000, 1'b1, 1'b1);
	allow_check("status_and_mirroring allow prg", 16'hC000, 1'b1, 1'b1);
	allow_check("status_and_mirroring allow bios wr", 16'hE000, 1'b1, 1'b0);
	allow_check("status_and_mirroring allow rom rd", 16'h8000, 1'b0, 1'b1);
	allow_check("status_and_mirroring allow offset", 16'hF4D0, 1'b0, 1'b0);
	allow_check("status_and_mirroring allow regs", 16'h4020, 1'b0, 1'b0);
	bus_write(16'h4025, 8'h04);
	mirror_check(14'h0400, 1'b1);
	mirror_check(14'h0800, 1'b0);
	bus_write(16'h4025, 8'h0C);
	mirror_check(14'h0400, 1'b0);
	mirror_check(14'h0800, 1'b1);
	mirror_check(14'h2800, 1'b1);  // nametable space
	bus_write(16'h4027, 8'h02);
	compare("status_and_mirroring side 2", 2, disk_side_auto);
	bus_write(16'h4027, 8'h01);
	compare("status_and_mirroring side 1", 1, disk_side_auto);
endtask

`endif

// File: bench/fds_mapper_tb.sv
// fds mapper testbench: clock, reset, cpu strobes and the directed test sequence

module fds_mapper_tb;

	logic        clk20;
	logic        reset;
	logic        cpu_ce;
	logic [15:0] prg_ain;
	logic [7:0]  prg_din;
	logic        prg_write;
	logic [13:0] chr_ain;
	logic [7:0]  ram_dout;
	logic [1:0]  disk_side;
	logic        disk_eject;
	logic        drive_busy;
	logic [7:0]  prg_dout;
	logic        prg_bus_drive;
	logic        prg_allow;
	logic [21:0] prg_aout;
	logic [21:0] chr_aout;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;
	logic [1:0]  disk_side_auto;

	logic [21:0] seen_aout;  // outputs captured in the strobe cycle
	logic        seen_drive;
	int          error_count;

	fds_mapper u_fds_mapper (
		.clk20          (clk20),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.prg_ain        (prg_ain),
		.prg_din        (prg_din),
		.prg_write      (prg_write),
		.chr_ain        (chr_ain),
		.ram_dout       (ram_dout),
		.disk_side      (disk_side),
		.disk_eject     (disk_eject),
		.drive_busy     (drive_busy),
		.prg_dout       (prg_dout),
		.prg_bus_drive  (prg_bus_drive),
		.prg_allow      (prg_allow),
		.prg_aout       (prg_aout),
		.chr_aout       (chr_aout),
		.vram_a10       (vram_a10),
		.vram_ce        (vram_ce),
		.irq            (irq),
		.disk_side_auto (disk_side_auto)
	);

	bind fds_mapper fds_mapper_properties u_properties (
		.clk20    (clk20),
		.reset    (reset),
		.prg_aout (prg_aout),
		.irq      (irq)
	);

	task automatic stop_on_error();
		error_count++;
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	`include "fds_bench_tasks.svh"

	initial begin
		clk20 = 1'b0;
		forever #50 clk20 = ~clk20;
	end

	initial begin
		error_count = 0;
		void'($urandom(32'hd4a27e20));
		reset      = 1'b1;
		cpu_ce     = 1'b0;
		prg_ain    = 16'h0000;
		prg_din    = 8'h00;
		prg_write  = 1'b0;
		chr_ain    = 14'h0000;
		ram_dout   = 8'h00;
		disk_side  = 2'd0;
		disk_eject = 1'b0;
		drive_busy = 1'b0;
		seen_aout  = '0;
		seen_drive = 1'b0;
		repeat (8) @(posedge clk20);
		#1;
		reset = 1'b0;

		reset_defaults();
		timer_one_shot();
		disk_read_sequence();
		disk_reset();
		disk_write_sequence();
		status_and_mirroring();

		if (error_count == 0 && u_fds_mapper.u_properties.fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: fds_mapper.f
+incdir+include
hw/fds_pkg.sv
hw/fds_timer_irq.sv
hw/fds_disk_access.sv
hw/fds_prg_map.sv
hw/fds_mapper.sv
bench/fds_mapper_properties.sv
bench/fds_mapper_tb.sv

// File: hw/fds_disk_access.sv
// fds disk tracker: control registers, BIOS read/write sequences, position and side offset

module fds_disk_access (
	input  logic                           clk20,
	input  logic                           reset,
	input  logic                           cpu_ce,
	input  logic [fds_pkg::cpu_addr_w-1:0] prg_ain,
	input  logic [fds_pkg::data_w-1:0]     prg_din,
	input  logic                           prg_write,
	input  logic [1:0]                     disk_side,
	output fds_pkg::disk_access_e          read_state,
	output fds_pkg::disk_access_e          write_state,
	output logic [fds_pkg::disk_off_w-1:0] rom_offset,
	output logic                           disk_end,
	output logic                           saved,
	output logic                           disk_reg_en,
	output logic                           mirror_vertical,
	output logic [1:0]                     disk_side_auto
);

	logic [fds_pkg::disk_pos_w-1:0] disk_pos;
	logic [fds_pkg::disk_off_w-1:0] side_base;
	logic diskreset;     // $4025 bit1, holds position at 0
	logic write_en;      // $4025 bit2 low means write mode
	logic mirror_horiz;  // $4025 bit3

	logic cpu_wr;
	logic cpu_rd;

	assign cpu_wr = cpu_ce & prg_write;
	assign cpu_rd = cpu_ce & ~prg_write;

	assign mirror_vertical = ~mirror_horiz;

	// header + side * side length + position
	assign side_base  = fds_pkg::disk_side_len * {16'd0, disk_side};
	assign rom_offset = fds_pkg::disk_header_len + side_base + {2'b00, disk_pos};
	assign disk_end   = (disk_pos == fds_pkg::disk_last_pos);

	// $4023, $4025, $4027
	always_ff @(posedge clk20) begin
		if (reset) begin
			disk_reg_en    <= 1'b0;
			diskreset      <= 1'b0;
			write_en       <= 1'b0;
			mirror_horiz   <= 1'b1;
			disk_side_auto <= 2'd0;
		end else if (cpu_wr) begin
			case (prg_ain)
				fds_pkg::addr_disk_en: disk_reg_en <= prg_din[0];
				fds_pkg::addr_disk_ctrl: begin
					diskreset    <= prg_din[1];
					write_en     <= ~prg_din[2];
					mirror_horiz <= prg_din[3];
				end
				fds_pkg::addr_disk_side: disk_side_auto <= prg_din[1:0];
				default: ;
			endcase
		end
	end

	// lo/hi fetch pairs, any other cpu cycle drops back to idle
	always_ff @(posedge clk20) begin
		if (reset) begin
			read_state  <= fds_pkg::idle;
			write_state <= fds_pkg::idle;
			saved       <= 1'b0;
		end else if (cpu_ce) begin
			if (cpu_rd && prg_ain == fds_pkg::addr_read_lo)
				read_state <= fds_pkg::lo_seen;
			else if (cpu_rd && prg_ain == fds_pkg::addr_read_hi && read_state == fds_pkg::lo_seen)
				read_state <= fds_pkg::active;
			else
				read_state <= fds_pkg::idle;

			if (cpu_rd && write_en && prg_ain == fds_pkg::addr_write_lo)
				write_state <= fds_pkg::lo_seen;
			else if (cpu_rd && prg_ain == fds_pkg::addr_write_hi &&
					write_state == fds_pkg::lo_seen)
				write_state <= fds_pkg::active;
			else
				write_state <= fds_pkg::idle;

			if (write_state == fds_pkg::active)
				saved <= 1'b1;  // sticky until reset
		end
	end

	// disk byte pointer
	always_ff @(posedge clk20) begin
		if (reset) begin
			disk_pos <= '0;
		end else if (cpu_ce) begin
			if (diskreset)
				disk_pos <= '0;
			else if (read_state == fds_pkg::active && !disk_end)
				disk_pos <= disk_pos + 16'd1;
		end
	end

endmodule

// File: hw/fds_mapper.sv
// fds mapper top: timer irq, disk access tracker and PRG/CHR map

module fds_mapper (
	input  logic                           clk20,
	input  logic                           reset,
	input  logic                           cpu_ce,
	input  logic [fds_pkg::cpu_addr_w-1:0] prg_ain,
	input  logic [fds_pkg::data_w-1:0]     prg_din,
	input  logic                           prg_write,
	input  logic [13:0]                    chr_ain,
	input  logic [fds_pkg::data_w-1:0]     ram_dout,
	input  logic [1:0]                     disk_side,
	input  logic                           disk_eject,
	input  logic                           drive_busy,
	output logic [fds_pkg::data_w-1:0]     prg_dout,
	output logic                           prg_bus_drive,
	output logic                           prg_allow,
	output logic [fds_pkg::ext_addr_w-1:0] prg_aout,
	output logic [fds_pkg::ext_addr_w-1:0] chr_aout,
	output logic                           vram_a10,
	output logic                           vram_ce,
	output logic                           irq,
	output logic [1:0]                     disk_side_auto
);

	fds_pkg::disk_access_e read_state;
	fds_pkg::disk_access_e write_state;
	logic [fds_pkg::disk_off_w-1:0] rom_offset;
	logic disk_end;
	logic saved;
	logic disk_reg_en;
	logic mirror_vertical;

	fds_timer_irq u_timer_irq (
		.clk20       (clk20),
		.reset       (reset),
		.cpu_ce      (cpu_ce),
		.prg_ain     (prg_ain),
		.prg_din     (prg_din),
		.prg_write   (prg_write),
		.disk_reg_en (disk_reg_en),
		.irq         (irq)
	);

	fds_disk_access u_disk_access (
		.clk20           (clk20),
		.reset           (reset),
		.cpu_ce          (cpu_ce),
		.prg_ain         (prg_ain),
		.prg_din         (prg_din),
		.prg_write       (prg_write),
		.disk_side       (disk_side),
		.read_state      (read_state),
		.write_state     (write_state),
		.rom_offset      (rom_offset),
		.disk_end        (disk_end),
		.saved           (saved),
		.disk_reg_en     (disk_reg_en),
		.mirror_vertical (mirror_vertical),
		.disk_side_auto  (disk_side_auto)
	);

	fds_prg_map u_prg_map (
		.prg_ain         (prg_ain),
		.prg_write       (prg_write),
		.chr_ain         (chr_ain),
		.ram_dout        (ram_dout),
		.read_state      (read_state),
		.write_state     (write_state),
		.rom_offset      (rom_offset),
		.disk_end        (disk_end),
		.saved           (saved),
		.irq             (irq),
		.mirror_vertical (mirror_vertical),
		.disk_eject      (disk_eject),
		.drive_busy      (drive_busy),
		.prg_dout        (prg_dout),
		.prg_bus_drive   (prg_bus_drive),
		.prg_allow       (prg_allow),
		.prg_aout        (prg_aout),
		.chr_aout        (chr_aout),
		.vram_a10        (vram_a10),
		.vram_ce         (vram_ce)
	);

endmodule

// File: hw/fds_pkg.sv
// fds mapper package: register map, disk geometry, widths and access-sequence states

package fds_pkg;

	// bus and datapath widths
	localparam int cpu_addr_w = 16;
	localparam int data_w     = 8;
	localparam int disk_pos_w = 16;  // byte position within one side
	localparam int disk_off_w = 18;  // byte offset into the whole image
	localparam int ext_addr_w = 22;  // cartridge memory address

	// timer latch
	localparam logic [15:0] addr_timer_lo = 16'h4020;
	localparam logic [15:0] addr_timer_hi = 16'h4021;

	// control registers
	localparam logic [15:0] addr_timer_ctrl = 16'h4022;  // bit0 repeat, bit1 enable
	localparam logic [15:0] addr_disk_en    = 16'h4023;  // bit0 disk registers on
	localparam logic [15:0] addr_disk_ctrl  = 16'h4025;  // bit1 reset, bit2 read mode, bit3 mirror
	localparam logic [15:0] addr_disk_side  = 16'h4027;  // side the BIOS asked for

	// read-only status
	localparam logic [15:0] addr_irq_status   = 16'h4030;
	localparam logic [15:0] addr_drive_status = 16'h4032;
	localparam logic [15:0] addr_power        = 16'h4033;
	localparam logic [15:0] addr_busy         = 16'h4029;
	localparam logic [15:0] addr_save_flag    = 16'h4208;

	// patched BIOS fetch points that mark a disk byte transfer
	localparam logic [15:0] addr_read_lo  = 16'hF4D0;
	localparam logic [15:0] addr_read_hi  = 16'hF4D1;
	localparam logic [15:0] addr_write_lo = 16'hF4CD;
	localparam logic [15:0] addr_write_hi = 16'hF4CE;

	// disk image layout
	localparam logic [17:0] disk_side_len   = 18'd65500;
	localparam logic [17:0] disk_header_len = 18'd16;   // image header before side 0
	localparam logic [15:0] disk_last_pos   = 16'd65499;

	localparam logic [7:0] power_status_value = 8'h80;  // battery good

	// state of a lo/hi fetch pair
	typedef enum logic [1:0] {
		idle    = 2'd0,
		lo_seen = 2'd1,  // lo address fetched on the previous cpu cycle
		active  = 2'd2   // hi followed lo, transfer is in this cycle
	} disk_access_e;

endpackage

// File: hw/fds_prg_map.sv
// fds PRG/CHR mapping: bank select, status read override, access allow and mirroring

module fds_prg_map (
	input  logic [fds_pkg::cpu_addr_w-1:0] prg_ain,
	input  logic                           prg_write,
	input  logic [13:0]                    chr_ain,
	input  logic [fds_pkg::data_w-1:0]     ram_dout,
	input  fds_pkg::disk_access_e          read_state,
	input  fds_pkg::disk_access_e          write_state,
	input  logic [fds_pkg::disk_off_w-1:0] rom_offset,
	input  logic                           disk_end,
	input  logic                           saved,
	input  logic                           irq,
	input  logic                           mirror_vertical,
	input  logic                           disk_eject,
	input  logic                           drive_busy,
	output logic [fds_pkg::data_w-1:0]     prg_dout,
	output logic                           prg_bus_drive,
	output logic                           prg_allow,
	output logic [fds_pkg::ext_addr_w-1:0] prg_aout,
	output logic [fds_pkg::ext_addr_w-1:0] chr_aout,
	output logic                           vram_a10,
	output logic                           vram_ce
);

	logic any_active;
	logic write_active;
	logic match_lo;  // offset low byte, outside a transfer
	logic match_hi;
	logic [5:0] prg_bank;  // address bits 18:13

	assign write_active = (write_state == fds_pkg::active);
	assign any_active   = (read_state == fds_pkg::active) | write_active;

	assign match_lo = ((prg_ain == fds_pkg::addr_read_lo) |
			(prg_ain == fds_pkg::addr_write_lo)) & ~any_active;
	assign match_hi = ((prg_ain == fds_pkg::addr_read_hi) |
			(prg_ain == fds_pkg::addr_write_hi)) & ~any_active;

	// E000-FFFF is the BIOS, or the disk image during a transfer
	always_comb begin
		if (prg_ain[15:13] == 3'b111)
			prg_bank = any_active ? {1'b1, rom_offset[17:13]} : 6'd0;
		else
			prg_bank = {4'b0001, prg_ain[14:13]};  // 6000-DFFF in ram
	end

	assign prg_aout = {{3{prg_bank[5]}}, prg_bank, prg_ain[12:0]};

	// status and offset bytes replace the memory data
	always_comb begin
		prg_bus_drive = 1'b1;
		if (prg_ain == fds_pkg::addr_irq_status)
			prg_dout = {7'd0, irq};
		else if (prg_ain == fds_pkg::addr_drive_status)
			prg_dout = {5'd0, disk_eject, disk_end, disk_eject};
		else if (prg_ain == fds_pkg::addr_power)
			prg_dout = fds_pkg::power_status_value;
		else if (match_lo)
			prg_dout = rom_offset[7:0];
		else if (match_hi)
			prg_dout = {3'b111, rom_offset[12:8]};
		else if (prg_ain == fds_pkg::addr_save_flag)
			prg_dout = {7'd0, saved};
		else if (prg_ain == fds_pkg::addr_busy)
			prg_dout = {7'd0, ~drive_busy};  // zero while busy
		else begin
			prg_dout      = ram_dout;
			prg_bus_drive = 1'b0;
		end
	end

	// writes: 6000-DFFF or a disk write; reads: 6000-FFFF minus the offset bytes
	always_comb begin
		if (prg_write)
			prg_allow = write_active | (prg_ain[15] ^ (&prg_ain[14:13]));
		else
			prg_allow = (prg_ain[15] & ~match_lo & ~match_hi) |
					(prg_ain[15:13] == 3'b011);
	end

	assign chr_aout = {3'b010, 6'd0, chr_ain[12:0]};
	assign vram_a10 = mirror_vertical ? chr_ain[10] : chr_ain[11];
	assign vram_ce  = chr_ain[13];  // nametable space goes to internal vram

endmodule

// File: hw/fds_timer_irq.sv
// fds timer: 16-bit latch, down-counter and the timer interrupt flag

module fds_timer_irq (
	input  logic                          clk20,
	input  logic                          reset,
	input  logic                          cpu_ce,
	input  logic [fds_pkg::cpu_addr_w-1:0] prg_ain,
	input  logic [fds_pkg::data_w-1:0]     prg_din,
	input  logic                          prg_write,
	input  logic                          disk_reg_en,
	output logic                          irq
);

	logic [2*fds_pkg::data_w-1:0] timer_latch;
	logic [2*fds_pkg::data_w-1:0] timer_count;
	logic timer_en;
	logic timer_repeat;
	logic disk_reg_en_q;  // previous disk_reg_en, for the falling edge

	logic cpu_wr;
	logic cpu_rd;
	logic wr_ctrl;
	logic timer_start;
	logic expire;
	logic reg_off;
	logic irq_ack;

	assign cpu_wr = cpu_ce & prg_write;
	assign cpu_rd = cpu_ce & ~prg_write;

	assign wr_ctrl     = cpu_wr & (prg_ain == fds_pkg::addr_timer_ctrl);
	assign timer_start = wr_ctrl & prg_din[1] & disk_reg_en;
	assign expire      = cpu_ce & timer_en & (timer_count == '0);
	assign reg_off     = disk_reg_en_q & ~disk_reg_en;  // $4023 bit0 cleared
	assign irq_ack     = cpu_rd & (prg_ain == fds_pkg::addr_irq_status);

	// latch and counter
	always_ff @(posedge clk20) begin
		if (cpu_wr && prg_ain == fds_pkg::addr_timer_lo)
			timer_latch[7:0] <= prg_din;
		if (cpu_wr && prg_ain == fds_pkg::addr_timer_hi)
			timer_latch[15:8] <= prg_din;

		if (timer_start) begin
			timer_count <= timer_latch;
		end else if (cpu_ce && timer_en) begin
			if (timer_count == '0)
				timer_count <= timer_latch;  // reload on expiry
			else
				timer_count <= timer_count - 16'd1;
		end
	end

	// enable, repeat and irq; later statements take priority
	always_ff @(posedge clk20) begin
		if (reset) begin
			irq           <= 1'b0;
			timer_en      <= 1'b0;
			timer_repeat  <= 1'b0;
			disk_reg_en_q <= 1'b0;
		end else begin
			disk_reg_en_q <= disk_reg_en;

			if (expire) begin
				irq <= 1'b1;
				if (!timer_repeat)
					timer_en <= 1'b0;  // one-shot
			end

			if (wr_ctrl) begin
				timer_repeat <= prg_din[0];
				timer_en     <= timer_start;
				if (!timer_start)
					irq <= 1'b0;
			end

			if (reg_off) begin
				timer_en <= 1'b0;
				irq      <= 1'b0;
			end

			if (irq_ack)
				irq <= 1'b0;  // read of $4030 acknowledges
		end
	end

endmodule
